//--- build.f
+incdir+source
source/lc3Pkg.sv
source/memPort.sv
source/regFile.sv
source/aluUnit.sv
source/reqTracker.sv
source/controlFsm.sv
source/datapath.sv
source/lc3Core.sv
test/lc3CoreTb.sv

//--- source/aluUnit.sv
`timescale 1ns/1ps

module aluUnit
	import lc3Pkg::*;
(
	input logic [15:0] a,
	input logic [15:0] b,
	input aluOpT op,
	output logic [15:0] y
);
	always_comb
	begin
		case (op)
			aluAdd: y = a + b;
			aluAnd: y = a & b;
			aluNot: y = ~a;
			// pass, used to move SR onto the bus for stores.
			default: y = a;
		endcase
	end
endmodule

//--- source/controlFsm.sv
`timescale 1ns/1ps
`include "lc3_consts.svh"

module controlFsm
	import lc3Pkg::*;
(
	input logic Clk,
	input logic rst,
	input instrT ir,
	input logic ben,
	memPort.ctrl mem,
	output logic ldMar,
	output logic ldMdr,
	output logic ldIr,
	output logic ldPc,
	output logic ldReg,
	output logic ldCc,
	output logic gatePc,
	output logic gateMdr,
	output logic gateAlu,
	output logic gateMarmux,
	output logic [1:0] pcSel,
	output logic addr1Sel,
	output logic [1:0] addr2Sel,
	output logic drSel,
	output logic sr1Sel,
	output logic mioEn,
	output aluOpT aluOp,
	output logic halted,
	output logic fault
);
	stateT state;
	stateT nextState;

	always_ff @(posedge Clk)
	begin
		if (rst)
			state <= sFetch;
		else
			state <= nextState;
	end

	// ****************************************
	// next state.
	// ****************************************
	always_comb
	begin
		nextState = state;
		case (state)
			sFetch: nextState = sFetchReq;
			sFetchReq: if (mem.canIssue) nextState = sFetchWait;
			sFetchWait: if (mem.rdValid) nextState = sLoadIr;
			sLoadIr: nextState = sDecode;
			sDecode:
			begin
				case (ir.opr.opcode)
					opAdd, opAnd, opNot, opLea, opBr, opJmp: nextState = sExec;
					opLd: nextState = sLdAddr;
					opSt: nextState = sStAddr;
					// TRAP and anything unsupported stop the core.
					default: nextState = sHalt;
				endcase
			end
			sExec: nextState = sFetch;
			sLdAddr: nextState = sLdReq;
			sLdReq: if (mem.canIssue) nextState = sLdWait;
			sLdWait: if (mem.rdValid) nextState = sLdWb;
			sLdWb: nextState = sFetch;
			sStAddr: nextState = sStMdr;
			sStMdr: nextState = sStReq;
			// write goes out, fetch continues without waiting on it.
			sStReq: if (mem.canIssue) nextState = sFetch;
			default: nextState = state;
		endcase
		if (mem.timedOut && state != sHalt)
			nextState = sFault;
	end

	// ****************************************
	// control outputs.
	// ****************************************
	always_comb
	begin
		ldMar = 1'b0;
		ldMdr = 1'b0;
		ldIr = 1'b0;
		ldPc = 1'b0;
		ldReg = 1'b0;
		ldCc = 1'b0;
		gatePc = 1'b0;
		gateMdr = 1'b0;
		gateAlu = 1'b0;
		gateMarmux = 1'b0;
		pcSel = `LC3_PC_INC;
		addr1Sel = 1'b0;
		addr2Sel = `LC3_A2_ZERO;
		drSel = 1'b0;
		sr1Sel = 1'b0;
		mioEn = 1'b0;
		aluOp = aluPass;
		mem.req = 1'b0;
		mem.we = 1'b0;
		case (state)
			sFetch:
			begin
				gatePc = 1'b1;
				ldMar = 1'b1;
				ldPc = 1'b1;
			end
			sFetchReq, sLdReq: mem.req = mem.canIssue;
			sStReq:
			begin
				mem.req = mem.canIssue;
				mem.we = mem.canIssue;
			end
			sFetchWait, sLdWait: ldMdr = mem.rdValid;
			sLoadIr:
			begin
				gateMdr = 1'b1;
				ldIr = 1'b1;
			end
			sDecode:
			begin
				// trap keeps its return address in R7.
				if (ir.opr.opcode == opTrap)
				begin
					gatePc = 1'b1;
					ldReg = 1'b1;
					drSel = 1'b1;
				end
			end
			sExec:
			begin
				case (ir.opr.opcode)
					opAdd, opAnd, opNot:
					begin
						gateAlu = 1'b1;
						ldReg = 1'b1;
						ldCc = 1'b1;
						sr1Sel = 1'b1;
						if (ir.opr.opcode == opAdd)
							aluOp = aluAdd;
						else if (ir.opr.opcode == opAnd)
							aluOp = aluAnd;
						else
							aluOp = aluNot;
					end
					opLea:
					begin
						gateMarmux = 1'b1;
						addr2Sel = `LC3_A2_OFF9;
						ldReg = 1'b1;
						ldCc = 1'b1;
					end
					opBr:
					begin
						ldPc = ben;
						pcSel = `LC3_PC_ADDR;
						addr2Sel = `LC3_A2_OFF9;
					end
					default:
					begin
						// JMP, base register plus zero.
						ldPc = 1'b1;
						pcSel = `LC3_PC_ADDR;
						addr1Sel = 1'b1;
						sr1Sel = 1'b1;
					end
				endcase
			end
			sLdAddr, sStAddr:
			begin
				gateMarmux = 1'b1;
				addr2Sel = `LC3_A2_OFF9;
				ldMar = 1'b1;
			end
			sLdWb:
			begin
				gateMdr = 1'b1;
				ldReg = 1'b1;
				ldCc = 1'b1;
			end
			sStMdr:
			begin
				gateAlu = 1'b1;
				mioEn = 1'b1;
				ldMdr = 1'b1;
			end
			default: ;
		endcase
	end

	assign halted = (state == sHalt);
	assign fault = (state == sFault);

	assert property (@(posedge Clk) disable iff (rst)
		$onehot0({gatePc, gateMdr, gateAlu, gateMarmux}));
endmodule

//--- source/datapath.sv
`timescale 1ns/1ps
`include "lc3_consts.svh"

module datapath
	import lc3Pkg::*;
(
	input logic Clk,
	input logic rst,
	input logic ldMar,
	input logic ldMdr,
	input logic ldIr,
	input logic ldPc,
	input logic ldReg,
	input logic ldCc,
	input logic gatePc,
	input logic gateMdr,
	input logic gateAlu,
	input logic gateMarmux,
	input logic [1:0] pcSel,
	input logic addr1Sel,
	input logic [1:0] addr2Sel,
	input logic drSel,
	input logic sr1Sel,
	input logic mioEn,
	input aluOpT aluOp,
	memPort.data mem,
	output instrT ir,
	output logic ben,
	output logic [15:0] pc
);
	logic [15:0] bus;
	logic [15:0] mar;
	logic [15:0] mdr;
	logic [15:0] aluOut;
	logic [15:0] aluB;
	logic [15:0] sr1Out;
	logic [15:0] sr2Out;
	logic [15:0] addr1;
	logic [15:0] addr2;
	logic [15:0] addrSum;
	logic [15:0] pcNext;
	logic [2:0] drIdx;
	logic [2:0] sr1Idx;
	logic [2:0] cc;

	regFile regFile_inst (
		.Clk(Clk),
		.rst(rst),
		.we(ldReg),
		.dr(drIdx),
		.sr1(sr1Idx),
		.sr2(ir.opr.imm5[2:0]),
		.wdata(bus),
		.rd1(sr1Out),
		.rd2(sr2Out)
	);

	aluUnit aluUnit_inst (
		.a(sr1Out),
		.b(aluB),
		.op(aluOp),
		.y(aluOut)
	);

	assign drIdx = drSel ? 3'd7 : ir.ldst.drSr;
	assign sr1Idx = sr1Sel ? ir.opr.sr1 : ir.ldst.drSr;
	assign aluB = ir.opr.immFlag ? {{11{ir.opr.imm5[4]}}, ir.opr.imm5} : sr2Out;

	// ****************************************
	// bus, first gate wins.
	// ****************************************
	always_comb
	begin
		if (gateMdr)
			bus = mdr;
		else if (gateAlu)
			bus = aluOut;
		else if (gatePc)
			bus = pc;
		else if (gateMarmux)
			bus = addrSum;
		else
			bus = 16'd0;
	end

	// address adder.
	assign addr1 = addr1Sel ? sr1Out : pc;

	always_comb
	begin
		case (addr2Sel)
			`LC3_A2_ZERO: addr2 = 16'd0;
			`LC3_A2_OFF6: addr2 = {{10{ir[5]}}, ir[5:0]};
			`LC3_A2_OFF9: addr2 = {{7{ir.ldst.offset9[8]}}, ir.ldst.offset9};
			`LC3_A2_OFF11: addr2 = {{5{ir[10]}}, ir[10:0]};
		endcase
	end

	assign addrSum = addr1 + addr2;

	always_comb
	begin
		case (pcSel)
			`LC3_PC_INC: pcNext = pc + 16'd1;
			`LC3_PC_ADDR: pcNext = addrSum;
			`LC3_PC_BUS: pcNext = bus;
			default: pcNext = pc;
		endcase
	end

	always_ff @(posedge Clk)
	begin
		if (rst)
		begin
			pc <= `LC3_RESET_PC;
			cc <= 3'b010;
		end
		else
		begin
			if (ldPc)
				pc <= pcNext;
			if (ldCc)
				cc <= {bus[15], bus == 16'd0, !bus[15] && bus != 16'd0};
		end
	end

	always_ff @(posedge Clk)
	begin
		if (ldMar)
			mar <= bus;
		if (ldMdr)
			mdr <= mioEn ? bus : mem.rdData;
		if (ldIr)
			ir <= bus;
	end

	assign mem.addr = mar;
	assign mem.wdata = mdr;

	// n/z/p flags of BR against the codes.
	assign ben = (ir.br.n && cc[2]) || (ir.br.z && cc[1]) || (ir.br.p && cc[0]);
endmodule

//--- source/lc3Core.sv
`timescale 1ns/1ps

module lc3Core
	import lc3Pkg::*;
(
	input logic Clk,
	input logic rst,
	input logic memCredit,
	input logic rdValid,
	input logic [15:0] rdData,
	output logic memReq,
	output logic memWe,
	output logic [15:0] memAddr,
	output logic [15:0] memWdata,
	output logic halted,
	output logic fault,
	output logic [15:0] pc
);
	logic ldMar;
	logic ldMdr;
	logic ldIr;
	logic ldPc;
	logic ldReg;
	logic ldCc;
	logic gatePc;
	logic gateMdr;
	logic gateAlu;
	logic gateMarmux;
	logic [1:0] pcSel;
	logic addr1Sel;
	logic [1:0] addr2Sel;
	logic drSel;
	logic sr1Sel;
	logic mioEn;
	aluOpT aluOp;
	instrT ir;
	logic ben;

	memPort memBus ();

	// memory pins.
	assign memReq = memBus.req;
	assign memWe = memBus.we;
	assign memAddr = memBus.addr;
	assign memWdata = memBus.wdata;
	assign memBus.rdValid = rdValid;
	assign memBus.rdData = rdData;

	reqTracker reqTracker_inst (
		.Clk(Clk),
		.rst(rst),
		.memCredit(memCredit),
		.mem(memBus.track)
	);

	controlFsm controlFsm_inst (
		.Clk(Clk),
		.rst(rst),
		.ir(ir),
		.ben(ben),
		.mem(memBus.ctrl),
		.ldMar(ldMar),
		.ldMdr(ldMdr),
		.ldIr(ldIr),
		.ldPc(ldPc),
		.ldReg(ldReg),
		.ldCc(ldCc),
		.gatePc(gatePc),
		.gateMdr(gateMdr),
		.gateAlu(gateAlu),
		.gateMarmux(gateMarmux),
		.pcSel(pcSel),
		.addr1Sel(addr1Sel),
		.addr2Sel(addr2Sel),
		.drSel(drSel),
		.sr1Sel(sr1Sel),
		.mioEn(mioEn),
		.aluOp(aluOp),
		.halted(halted),
		.fault(fault)
	);

	datapath datapath_inst (
		.Clk(Clk),
		.rst(rst),
		.ldMar(ldMar),
		.ldMdr(ldMdr),
		.ldIr(ldIr),
		.ldPc(ldPc),
		.ldReg(ldReg),
		.ldCc(ldCc),
		.gatePc(gatePc),
		.gateMdr(gateMdr),
		.gateAlu(gateAlu),
		.gateMarmux(gateMarmux),
		.pcSel(pcSel),
		.addr1Sel(addr1Sel),
		.addr2Sel(addr2Sel),
		.drSel(drSel),
		.sr1Sel(sr1Sel),
		.mioEn(mioEn),
		.aluOp(aluOp),
		.mem(memBus.data),
		.ir(ir),
		.ben(ben),
		.pc(pc)
	);
endmodule

//--- source/lc3Pkg.sv
package lc3Pkg;

	typedef enum logic [3:0] {
		opBr   = 4'h0,
		opAdd  = 4'h1,
		opLd   = 4'h2,
		opSt   = 4'h3,
		opJsr  = 4'h4,
		opAnd  = 4'h5,
		opLdr  = 4'h6,
		opStr  = 4'h7,
		opRti  = 4'h8,
		opNot  = 4'h9,
		opLdi  = 4'ha,
		opSti  = 4'hb,
		opJmp  = 4'hc,
		opRes  = 4'hd,
		opLea  = 4'he,
		opTrap = 4'hf
	} opcodeT;

	typedef enum logic [3:0] {
		sFetch,
		sFetchReq,
		sFetchWait,
		sLoadIr,
		sDecode,
		sExec,
		sLdAddr,
		sLdReq,
		sLdWait,
		sLdWb,
		sStAddr,
		sStMdr,
		sStReq,
		sHalt,
		sFault
	} stateT;

	typedef enum logic [1:0] {
		aluAdd,
		aluAnd,
		aluNot,
		aluPass
	} aluOpT;

	// ****************************************
	// instruction views over IR.
	// ****************************************
	typedef struct packed {
		opcodeT opcode;
		logic [2:0] dr;
		logic [2:0] sr1;
		logic immFlag;
		logic [4:0] imm5;
	} oprViewT;

	typedef struct packed {
		opcodeT opcode;
		logic [2:0] drSr;
		logic [8:0] offset9;
	} memViewT;

	typedef struct packed {
		opcodeT opcode;
		logic n;
		logic z;
		logic p;
		logic [8:0] offset9;
	} brViewT;

	typedef union packed {
		oprViewT opr;
		memViewT ldst;
		brViewT br;
	} instrT;

endpackage

//--- source/lc3_consts.svh
`ifndef LC3_CONSTS_SVH
`define LC3_CONSTS_SVH

// memory port credits and read timeout.
`define LC3_MEM_CREDITS 2
`define LC3_CREDIT_W 2
`define LC3_READ_TIMEOUT 64
`define LC3_TIMER_W 7

// core.
`define LC3_NUM_REGS 8
`define LC3_RESET_PC 16'h3000

// pc mux selects.
`define LC3_PC_INC 2'd0
`define LC3_PC_ADDR 2'd1
`define LC3_PC_BUS 2'd2

// addr2 mux selects.
`define LC3_A2_ZERO 2'd0
`define LC3_A2_OFF6 2'd1
`define LC3_A2_OFF9 2'd2
`define LC3_A2_OFF11 2'd3

`endif

//--- source/memPort.sv
`timescale 1ns/1ps

interface memPort;
	logic req;
	logic we;
	logic [15:0] addr;
	logic [15:0] wdata;
	logic rdValid;
	logic [15:0] rdData;
	logic canIssue;
	logic timedOut;

	// request side of the control FSM.
	modport ctrl (
		output req, we,
		input canIssue, rdValid, timedOut
	);

	// MAR and MDR toward memory.
	modport data (
		output addr, wdata,
		input rdData
	);

	modport track (
		input req, we, rdValid,
		output canIssue, timedOut
	);

	// memory facing side, mapped onto the core pins.
	modport host (
		input req, we, addr, wdata,
		output rdValid, rdData
	);
endinterface

//--- source/regFile.sv
`timescale 1ns/1ps
`include "lc3_consts.svh"

module regFile (
	input logic Clk,
	input logic rst,
	input logic we,
	input logic [$clog2(`LC3_NUM_REGS)-1:0] dr,
	input logic [$clog2(`LC3_NUM_REGS)-1:0] sr1,
	input logic [$clog2(`LC3_NUM_REGS)-1:0] sr2,
	input logic [15:0] wdata,
	output logic [15:0] rd1,
	output logic [15:0] rd2
);
	logic [15:0] regs [`LC3_NUM_REGS];

	always_ff @(posedge Clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < `LC3_NUM_REGS; i++)
				regs[i] <= 16'd0;
		end
		else if (we)
		begin
			regs[dr] <= wdata;
		end
	end

	// reads see the old value during a write.
	assign rd1 = regs[sr1];
	assign rd2 = regs[sr2];
endmodule

//--- source/reqTracker.sv
`timescale 1ns/1ps
`include "lc3_consts.svh"

module reqTracker (
	input logic Clk,
	input logic rst,
	input logic memCredit,
	memPort.track mem
);
	logic [`LC3_CREDIT_W-1:0] credits;
	logic [`LC3_CREDIT_W-1:0] pending;
	logic [`LC3_TIMER_W-1:0] timer;
	logic readIssue;

	assign readIssue = mem.req && !mem.we;
	assign mem.canIssue = (credits != '0);
	assign mem.timedOut = (pending != '0) && !mem.rdValid && (timer == `LC3_READ_TIMEOUT - 1);

	// credit pool, a return and a spend in one cycle cancel.
	always_ff @(posedge Clk)
	begin
		if (rst)
			credits <= `LC3_CREDIT_W'(`LC3_MEM_CREDITS);
		else if (mem.req && !memCredit)
			credits <= credits - 1'b1;
		else if (memCredit && !mem.req && credits != `LC3_MEM_CREDITS)
			credits <= credits + 1'b1;
	end

	// reads still waiting for data.
	always_ff @(posedge Clk)
	begin
		if (rst)
			pending <= '0;
		else if (readIssue && !mem.rdValid)
			pending <= pending + 1'b1;
		else if (mem.rdValid && !readIssue && pending != '0)
			pending <= pending - 1'b1;
	end

	// age of the oldest read, holds once expired.
	always_ff @(posedge Clk)
	begin
		if (rst)
			timer <= '0;
		else if (pending == '0 || mem.rdValid)
			timer <= '0;
		else if (timer != `LC3_READ_TIMEOUT)
			timer <= timer + 1'b1;
	end

	assert property (@(posedge Clk) disable iff (rst) mem.req |-> mem.canIssue);

	// memory never hands back more credits than it was given.
	assert property (@(posedge Clk) disable iff (rst)
		memCredit && !mem.req |-> credits != `LC3_MEM_CREDITS);
endmodule

//--- test/lc3CoreTb.sv
`timescale 1ns/1ps
`include "lc3_consts.svh"

module lc3CoreTb;
	localparam int RUN_LIMIT = 4000;
	localparam int DROP_READ = 20;
	localparam int IMG = 'h10;
	localparam int STORES = 'h80;
	localparam int LATS = 'hc0;

	logic Clk;
	logic rst;
	logic memCredit;
	logic rdValid;
	logic [15:0] rdData;
	logic memReq;
	logic memWe;
	logic [15:0] memAddr;
	logic [15:0] memWdata;
	logic halted;
	logic fault;
	logic [15:0] pc;

	logic [15:0] vec [0:255];
	logic [15:0] mem [0:65535];
	int rdDue [$];
	logic [15:0] rdAddr [$];
	int creditDue [$];
	int errs [1:6];
	int runMode;
	int cycle;
	int outstanding;
	int storeIdx;
	int readIdx;
	int dropCycle;
	int stallCycles;
	bit firstSeen;
	int failedTests;

	lc3Core lc3Core_inst (
		.Clk(Clk),
		.rst(rst),
		.memCredit(memCredit),
		.rdValid(rdValid),
		.rdData(rdData),
		.memReq(memReq),
		.memWe(memWe),
		.memAddr(memAddr),
		.memWdata(memWdata),
		.halted(halted),
		.fault(fault),
		.pc(pc)
	);

	always #10 Clk = ~Clk;

	function automatic int readLatency();
		if (runMode == 0)
			return int'(vec[LATS + readIdx % int'(vec[3])]);
		else
			return 1 + int'($urandom % 6);
	endfunction

	// slow credit return starves the core.
	function automatic int creditDelay();
		if (runMode == 1)
			return 12 + int'($urandom % 9);
		else
			return 1 + int'($urandom % 3);
	endfunction

	function automatic int storeTest();
		if (runMode == 1)
			return 4;
		else if (runMode == 2)
			return 6;
		else if (storeIdx < int'(vec[1]))
			return int'(vec[STORES + 3 * storeIdx]);
		else
			return 3;
	endfunction

	task automatic checkWord(input string name, input logic [15:0] got,
		input logic [15:0] exp, input int t);
		assert (got === exp)
		else
		begin
			$display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, exp, got);
			errs[t]++;
		end
	endtask

	task automatic recordStore();
		int t;
		int p;
		t = storeTest();
		p = STORES + 3 * storeIdx;
		mem[memAddr] = memWdata;
		assert (storeIdx < int'(vec[1]))
		else
		begin
			$display("unexpected store of %h to %h at %0t", memWdata, memAddr, $time);
			errs[t]++;
		end
		if (storeIdx < int'(vec[1]))
		begin
			checkWord("memAddr", memAddr, vec[p + 1], t);
			checkWord("memWdata", memWdata, vec[p + 2], t);
		end
		storeIdx++;
		creditDue.push_back(cycle + creditDelay());
	endtask

	task automatic issueRead();
		readIdx++;
		if (runMode == 2 && readIdx == DROP_READ)
			dropCycle = cycle;
		else
		begin
			rdAddr.push_back(memAddr);
			rdDue.push_back(cycle + readLatency());
		end
	endtask

	// ****************************************
	// memory model stepped once per clock.
	// ****************************************
	task automatic stepCycle();
		int k;
		@(negedge Clk);
		cycle++;
		memCredit = 1'b0;
		rdValid = 1'b0;
		rdData = 16'h0000;
		if (outstanding == `LC3_MEM_CREDITS)
			stallCycles++;
		if (memReq)
		begin
			assert (outstanding < `LC3_MEM_CREDITS)
			else
			begin
				$display("memReq at %0t with all %0d credits in use", $time, `LC3_MEM_CREDITS);
				errs[runMode == 2 ? 6 : 4]++;
			end
			assert (!halted && !fault)
			else
			begin
				$display("memReq at %0t after the core stopped", $time);
				errs[runMode == 0 ? 5 : (runMode == 1 ? 4 : 6)]++;
			end
			if (!firstSeen)
			begin
				assert (!memWe)
				else
				begin
					$display("first request at %0t is a write, not a fetch", $time);
					errs[1]++;
				end
				checkWord("memAddr", memAddr, `LC3_RESET_PC, 1);
				firstSeen = 1'b1;
			end
			outstanding++;
			if (memWe)
				recordStore();
			else
				issueRead();
		end
		// reads answer in request order.
		if (rdDue.size() > 0 && rdDue[0] <= cycle)
		begin
			rdValid = 1'b1;
			rdData = mem[rdAddr[0]];
			rdDue.delete(0);
			rdAddr.delete(0);
			creditDue.push_back(cycle + creditDelay());
		end
		// one credit per cycle at most.
		k = 0;
		while (k < creditDue.size() && !memCredit)
		begin
			if (creditDue[k] <= cycle)
			begin
				memCredit = 1'b1;
				outstanding--;
				creditDue.delete(k);
			end
			else
				k++;
		end
	endtask

	task automatic applyReset();
		@(negedge Clk);
		rst = 1'b1;
		memCredit = 1'b0;
		rdValid = 1'b0;
		rdData = 16'h0000;
		repeat (8) @(negedge Clk);
		if (runMode == 0)
		begin
			assert (!memReq && !memWe && !halted && !fault)
			else
			begin
				$display("outputs not idle at the end of reset, %0t", $time);
				errs[1]++;
			end
			checkWord("pc", pc, `LC3_RESET_PC, 1);
		end
		rst = 1'b0;
	endtask

	task automatic checkHalt();
		int t;
		int ht;
		ht = (runMode == 1) ? 4 : 5;
		assert (halted && !fault)
		else
		begin
			$display("core did not halt within %0d cycles, fault is %b", RUN_LIMIT, fault);
			errs[ht]++;
		end
		checkWord("pc", pc, vec[2], ht);
		// writes in flight drain here.
		repeat (20) stepCycle();
		t = storeTest();
		assert (storeIdx == int'(vec[1]))
		else
		begin
			$display("only %0d of %0d expected stores were seen", storeIdx, vec[1]);
			errs[t]++;
		end
		if (runMode == 1)
		begin
			assert (stallCycles > 0)
			else
			begin
				$display("credits never ran out, back-pressure was not exercised");
				errs[4]++;
			end
		end
	endtask

	task automatic checkFault();
		assert (fault)
		else
		begin
			$display("fault never rose after read %0d was dropped", DROP_READ);
			errs[6]++;
		end
		assert (dropCycle >= 0 && cycle - dropCycle >= `LC3_READ_TIMEOUT
			&& cycle - dropCycle <= `LC3_READ_TIMEOUT + 2)
		else
		begin
			$display("fault rose %0d cycles after the dropped read", cycle - dropCycle);
			errs[6]++;
		end
		repeat (20) stepCycle();
		assert (fault && !halted)
		else
		begin
			$display("fault did not hold until reset");
			errs[6]++;
		end
	endtask

	task automatic runProgram(input int mode);
		int a;
		int n;
		runMode = mode;
		for (a = 0; a < 65536; a++)
			mem[a] = 16'(a) ^ 16'h5ac3;
		for (a = 0; a < int'(vec[0]); a++)
			mem[`LC3_RESET_PC + a] = vec[IMG + a];
		rdDue.delete();
		rdAddr.delete();
		creditDue.delete();
		cycle = 0;
		outstanding = 0;
		storeIdx = 0;
		readIdx = 0;
		dropCycle = -1;
		stallCycles = 0;
		firstSeen = (mode != 0);
		applyReset();
		n = 0;
		while (!halted && !fault && n < RUN_LIMIT)
		begin
			stepCycle();
			n++;
		end
		if (mode == 2)
			checkFault();
		else
			checkHalt();
	endtask

	task automatic reportTest(input int t, input string name);
		if (errs[t] == 0)
			$display("test %0d %s: ok", t, name);
		else
		begin
			$display("test %0d %s: %0d errors", t, name, errs[t]);
			failedTests++;
		end
	endtask

	initial
	begin
		int total;
		Clk = 1'b0;
		rst = 1'b1;
		memCredit = 1'b0;
		rdValid = 1'b0;
		rdData = 16'h0000;
		void'($urandom(92506));
		$readmemh("test/lc3Vectors.txt", vec);

		runProgram(0);
		reportTest(1, "reset state and first fetch");
		reportTest(2, "arithmetic and LEA stores");
		reportTest(3, "LD and BR on condition codes");
		reportTest(5, "TRAP halt and final pc");
		runProgram(1);
		reportTest(4, "credit back-pressure");
		runProgram(2);
		reportTest(6, "read timeout fault");

		total = 0;
		for (int t = 1; t <= 6; t++)
			total += errs[t];
		$display("6 tests, %0d failed, %0d errors", failedTests, total);
		if (total == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end
endmodule

//--- test/lc3Vectors.txt
// header: program length, store count, final pc, latency count
// image words from 3000h; stores: test, address, data; read latencies in cycles
@000
0033 0008 3020 0008
@010
5020 // 3000 AND R0,R0,#0
1227 // 3001 ADD R1,R0,#7
147D // 3002 ADD R2,R1,#-3
1642 // 3003 ADD R3,R1,R2
58C1 // 3004 AND R4,R3,R1
9AFF // 3005 NOT R5,R3
5D6F // 3006 AND R6,R5,#15
EE05 // 3007 LEA R7,300D
3637 // 3008 ST R3,3040
3837 // 3009 ST R4,3041
3A37 // 300A ST R5,3042
3C37 // 300B ST R6,3043
3E37 // 300C ST R7,3044
2222 // 300D LD R1,3030
0801 // 300E BRn 3010
3235 // 300F ST R1,3045 skipped
0601 // 3010 BRzp not taken
3234 // 3011 ST R1,3046
241E // 3012 LD R2,3031
0401 // 3013 BRz 3015
3432 // 3014 ST R2,3047 skipped
0A01 // 3015 BRnp not taken
3431 // 3016 ST R2,3048
261A // 3017 LD R3,3032
0201 // 3018 BRp 301A
362F // 3019 ST R3,3049 skipped
0C01 // 301A BRnz not taken
362E // 301B ST R3,304A
E802 // 301C LEA R4,301F
C100 // 301D JMP R4
382C // 301E ST R4,304B skipped
F025 // 301F TRAP x25
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
8001 0000 0005 // 3030 load data, negative zero positive
@080
0002 3040 000B
0002 3041 0003
0002 3042 FFF4
0002 3043 0004
0002 3044 300D
0003 3046 8001
0003 3048 0000
0003 304A 0005
@0C0
0001 0003 0006 0002 0005 0001 0004 0002
